// File: filelist.f
+incdir+src
src/cpu_pkg.sv
src/fetch.sv
src/decode_reg_r.sv
src/execute.sv
src/mem_wb.sv
src/cpu.sv
testbench/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cpu testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  -f filelist.f --top-module cpu_tb -o cpu_sim

output=$(./obj_dir/cpu_sim)
echo "$output"

if echo "$output" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1

// File: src/cpu.sv
`include "cpu_consts.svh"

module cpu
  import cpu_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               run_i,
  input  logic               imem_we_i,
  input  logic [`ADDR_W-1:0] imem_addr_i,
  input  logic [31:0]        imem_data_i,
  output logic               wb_en_o,
  output logic [3:0]         wb_addr_o,
  output logic [31:0]        wb_data_o
);

  // fetch to decode
  logic               f_valid;
  logic [31:0]        f_inst;
  logic [`ADDR_W-1:0] f_pc;
  logic               stall;
  logic               branch;
  logic [`ADDR_W-1:0] branch_target;

  // decode to execute
  logic        d_valid, d_set_flags, d_use_imm;
  logic [3:0]  d_cond, d_r1_addr, d_r2_addr, d_rd_addr;
  alu_op_e     d_alu_op;
  logic [31:0] d_imm, d_r1, d_r2;
  logic        d_is_load, d_is_store, d_is_branch;

  // execute to mem_wb
  logic               e_valid, e_do_write, e_is_load, e_is_store;
  logic [3:0]         e_rd_addr;
  logic [31:0]        e_alu_data, e_store_data;
  logic [`ADDR_W-1:0] e_mem_addr;

  fetch fetch_i (
    .clk, .arst_n_i, .run_i, .imem_we_i, .imem_addr_i, .imem_data_i,
    .stall_i(stall), .branch_i(branch), .branch_target_i(branch_target),
    .valid_o(f_valid), .inst_o(f_inst), .pc_o(f_pc)
  );

  decode_reg_r decode_i (
    .clk, .arst_n_i, .valid_i(f_valid), .inst_i(f_inst), .pc_i(f_pc),
    .flush_i(branch), .wb_en_i(wb_en_o), .wb_addr_i(wb_addr_o), .wb_data_i(wb_data_o),
    .valid_o(d_valid), .cond_o(d_cond), .alu_op_o(d_alu_op), .set_flags_o(d_set_flags),
    .use_imm_o(d_use_imm), .imm_o(d_imm), .r1_o(d_r1), .r2_o(d_r2),
    .r1_addr_o(d_r1_addr), .r2_addr_o(d_r2_addr), .rd_addr_o(d_rd_addr),
    .is_load_o(d_is_load), .is_store_o(d_is_store), .is_branch_o(d_is_branch),
    .stall_o(stall)
  );

  execute execute_i (
    .clk, .arst_n_i, .valid_i(d_valid), .cond_i(d_cond), .alu_op_i(d_alu_op),
    .set_flags_i(d_set_flags), .use_imm_i(d_use_imm), .imm_i(d_imm),
    .r1_i(d_r1), .r2_i(d_r2), .r1_addr_i(d_r1_addr), .r2_addr_i(d_r2_addr),
    .rd_addr_i(d_rd_addr), .is_load_i(d_is_load), .is_store_i(d_is_store),
    .is_branch_i(d_is_branch), .wb_en_i(wb_en_o), .wb_addr_i(wb_addr_o),
    .wb_data_i(wb_data_o), .valid_o(e_valid), .do_write_o(e_do_write),
    .rd_addr_o(e_rd_addr), .alu_data_o(e_alu_data), .store_data_o(e_store_data),
    .is_load_o(e_is_load), .is_store_o(e_is_store), .mem_addr_o(e_mem_addr),
    .branch_o(branch), .branch_target_o(branch_target)
  );

  mem_wb mem_wb_i (
    .clk, .arst_n_i, .valid_i(e_valid), .do_write_i(e_do_write), .rd_addr_i(e_rd_addr),
    .alu_data_i(e_alu_data), .store_data_i(e_store_data), .is_load_i(e_is_load),
    .is_store_i(e_is_store), .mem_addr_i(e_mem_addr),
    .wb_en_o, .wb_addr_o, .wb_data_o
  );

endmodule

// File: src/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define NUM_REGS   16
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256
`define ADDR_W     8
`define REG_PC     4'd15  // never written, marks "no destination"

// data processing opcodes
`define OP_AND 4'h0
`define OP_EOR 4'h1
`define OP_SUB 4'h2
`define OP_ADD 4'h4
`define OP_CMP 4'hA
`define OP_ORR 4'hC
`define OP_MOV 4'hD

// condition field
`define COND_EQ 4'h0
`define COND_NE 4'h1
`define COND_CS 4'h2
`define COND_CC 4'h3
`define COND_MI 4'h4
`define COND_PL 4'h5
`define COND_VS 4'h6
`define COND_VC 4'h7
`define COND_HI 4'h8
`define COND_LS 4'h9
`define COND_GE 4'hA
`define COND_LT 4'hB
`define COND_GT 4'hC
`define COND_LE 4'hD
`define COND_AL 4'hE
`define COND_NV 4'hF

// instruction class, bits 27:26
`define CLASS_DP  2'b00
`define CLASS_SDT 2'b01
`define CLASS_BR  2'b10

`endif

// File: src/cpu_pkg.sv
package cpu_pkg;

  // data processing view
  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] cls;
    logic       imm;       // op2 is imm8 when set
    logic [3:0] opcode;
    logic       s;
    logic [3:0] rn;
    logic [3:0] rd;
    logic [3:0] unused;
    logic [7:0] op2;       // imm8, or rm in the low nibble
  } dp_t;

  // single data transfer view
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  cls;
    logic [1:0]  rsvd_hi;  // I and P, not decoded
    logic        u;        // add offset when set
    logic [1:0]  rsvd_lo;  // B and W, not decoded
    logic        l;        // load when set
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] offset;
  } sdt_t;

  // branch view
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  cls;
    logic        rsvd;
    logic        link;     // ignored
    logic [23:0] offset;
  } br_t;

  typedef union packed {
    dp_t  dp;
    sdt_t sdt;
    br_t  br;
  } inst_u;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_ORR,
    ALU_EOR,
    ALU_MOV,
    ALU_PASS_B
  } alu_op_e;

endpackage

// File: src/decode_reg_r.sv
`include "cpu_consts.svh"

module decode_reg_r
  import cpu_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               valid_i,
  input  logic [31:0]        inst_i,
  input  logic [`ADDR_W-1:0] pc_i,
  input  logic               flush_i,
  input  logic               wb_en_i,
  input  logic [3:0]         wb_addr_i,
  input  logic [31:0]        wb_data_i,
  output logic               valid_o,
  output logic [3:0]         cond_o,
  output alu_op_e            alu_op_o,
  output logic               set_flags_o,
  output logic               use_imm_o,
  output logic [31:0]        imm_o,
  output logic [31:0]        r1_o,
  output logic [31:0]        r2_o,
  output logic [3:0]         r1_addr_o,
  output logic [3:0]         r2_addr_o,
  output logic [3:0]         rd_addr_o,
  output logic               is_load_o,
  output logic               is_store_o,
  output logic               is_branch_o,
  output logic               stall_o
);

  inst_u       ins;
  logic        is_dp, is_sdt, is_br;
  logic        use_r1, use_r2;
  logic [3:0]  r1_addr, r2_addr, rd_addr;
  logic [31:0] r1_val, r2_val, imm, br_sum;
  alu_op_e     alu_op;
  logic [31:0] regs [`NUM_REGS];

  assign ins    = inst_i;
  assign is_dp  = ins.dp.cls == `CLASS_DP;
  assign is_sdt = ins.dp.cls == `CLASS_SDT;
  assign is_br  = ins.dp.cls == `CLASS_BR;

  // ************************************************************
  // decode
  // ************************************************************
  assign r1_addr = is_br ? 4'd0 : ins.dp.rn;
  assign r2_addr = is_sdt ? ins.sdt.rd : ins.dp.op2[3:0];  // store data or rm
  assign use_r1  = (is_dp && ins.dp.opcode != `OP_MOV) || is_sdt;
  assign use_r2  = (is_dp && !ins.dp.imm) || (is_sdt && !ins.sdt.l);

  // branch target in words, pc reads two ahead
  assign br_sum = {24'd0, pc_i} + 32'd2 + {{8{ins.br.offset[23]}}, ins.br.offset};

  always_comb begin
    imm     = {24'd0, ins.dp.op2};
    alu_op  = ALU_PASS_B;
    rd_addr = `REG_PC;                      // no destination by default
    if (is_dp) begin
      if (ins.dp.opcode != `OP_CMP) rd_addr = ins.dp.rd;
      case (ins.dp.opcode)
        `OP_AND: alu_op = ALU_AND;
        `OP_EOR: alu_op = ALU_EOR;
        `OP_SUB: alu_op = ALU_SUB;
        `OP_CMP: alu_op = ALU_SUB;
        `OP_ADD: alu_op = ALU_ADD;
        `OP_ORR: alu_op = ALU_ORR;
        `OP_MOV: alu_op = ALU_MOV;
        default: alu_op = ALU_ADD;
      endcase
    end else if (is_sdt) begin
      imm    = {20'd0, ins.sdt.offset};
      alu_op = ins.sdt.u ? ALU_ADD : ALU_SUB;
      if (ins.sdt.l) rd_addr = ins.sdt.rd;
    end else if (is_br) begin
      imm = {24'd0, br_sum[7:0]};
    end
  end

  // register file, write-through on the read ports
  always_ff @(posedge clk) begin
    if (wb_en_i) regs[wb_addr_i] <= wb_data_i;
  end

  assign r1_val = (wb_en_i && wb_addr_i == r1_addr) ? wb_data_i : regs[r1_addr];
  assign r2_val = (wb_en_i && wb_addr_i == r2_addr) ? wb_data_i : regs[r2_addr];

  // load in execute feeding this instruction
  assign stall_o = valid_i && valid_o && is_load_o &&
                   ((use_r1 && r1_addr == rd_addr_o) || (use_r2 && r2_addr == rd_addr_o));

  // ************************************************************
  // stage register
  // ************************************************************
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) valid_o <= 1'b0;
    else           valid_o <= valid_i && !flush_i && !stall_o;  // bubble on stall
  end

  always_ff @(posedge clk) begin
    if (!stall_o) begin
      cond_o      <= ins.dp.cond;
      alu_op_o    <= alu_op;
      set_flags_o <= is_dp && (ins.dp.s || ins.dp.opcode == `OP_CMP);
      use_imm_o   <= !is_dp || ins.dp.imm;
      imm_o       <= imm;
      r1_o        <= r1_val;
      r2_o        <= r2_val;
      r1_addr_o   <= r1_addr;
      r2_addr_o   <= r2_addr;
      rd_addr_o   <= rd_addr;
      is_load_o   <= is_sdt && ins.sdt.l;
      is_store_o  <= is_sdt && !ins.sdt.l;
      is_branch_o <= is_br;
    end
  end

  a_no_pc_write: assert property (
    @(posedge clk) disable iff (!arst_n_i) wb_en_i |-> wb_addr_i != `REG_PC
  ) else $error("write-back to r15");

endmodule

// File: src/execute.sv
`include "cpu_consts.svh"

module execute
  import cpu_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               valid_i,
  input  logic [3:0]         cond_i,
  input  alu_op_e            alu_op_i,
  input  logic               set_flags_i,
  input  logic               use_imm_i,
  input  logic [31:0]        imm_i,
  input  logic [31:0]        r1_i,
  input  logic [31:0]        r2_i,
  input  logic [3:0]         r1_addr_i,
  input  logic [3:0]         r2_addr_i,
  input  logic [3:0]         rd_addr_i,
  input  logic               is_load_i,
  input  logic               is_store_i,
  input  logic               is_branch_i,
  input  logic               wb_en_i,
  input  logic [3:0]         wb_addr_i,
  input  logic [31:0]        wb_data_i,
  output logic               valid_o,
  output logic               do_write_o,
  output logic [3:0]         rd_addr_o,
  output logic [31:0]        alu_data_o,
  output logic [31:0]        store_data_o,
  output logic               is_load_o,
  output logic               is_store_o,
  output logic [`ADDR_W-1:0] mem_addr_o,
  output logic               branch_o,
  output logic [`ADDR_W-1:0] branch_target_o
);

  logic        n_q, z_q, c_q, v_q;  // cpsr
  logic        cond_ok, pass, arith;
  logic [31:0] op_a, reg_b, op_b, res;
  logic [32:0] add_sum, sub_sum;
  logic        carry, ovf;

  // ************************************************************
  // forwarding, own result first, then write-back
  // ************************************************************
  always_comb begin
    if (do_write_o && !is_load_o && rd_addr_o == r1_addr_i) op_a = alu_data_o;
    else if (wb_en_i && wb_addr_i == r1_addr_i)              op_a = wb_data_i;
    else                                                     op_a = r1_i;
    if (do_write_o && !is_load_o && rd_addr_o == r2_addr_i) reg_b = alu_data_o;
    else if (wb_en_i && wb_addr_i == r2_addr_i)              reg_b = wb_data_i;
    else                                                     reg_b = r2_i;
  end

  assign op_b = use_imm_i ? imm_i : reg_b;

  always_comb begin
    case (cond_i)
      `COND_EQ: cond_ok = z_q;
      `COND_NE: cond_ok = !z_q;
      `COND_CS: cond_ok = c_q;
      `COND_CC: cond_ok = !c_q;
      `COND_MI: cond_ok = n_q;
      `COND_PL: cond_ok = !n_q;
      `COND_VS: cond_ok = v_q;
      `COND_VC: cond_ok = !v_q;
      `COND_HI: cond_ok = c_q && !z_q;
      `COND_LS: cond_ok = !c_q || z_q;
      `COND_GE: cond_ok = n_q == v_q;
      `COND_LT: cond_ok = n_q != v_q;
      `COND_GT: cond_ok = !z_q && (n_q == v_q);
      `COND_LE: cond_ok = z_q || (n_q != v_q);
      `COND_AL: cond_ok = 1'b1;
      `COND_NV: cond_ok = 1'b0;
      default:  cond_ok = 1'b0;
    endcase
  end

  assign pass = valid_i && cond_ok;  // failed condition becomes a bubble

  // ************************************************************
  // alu
  // ************************************************************
  assign add_sum = {1'b0, op_a} + {1'b0, op_b};
  assign sub_sum = {1'b0, op_a} + {1'b0, ~op_b} + 33'd1;
  assign arith   = (alu_op_i == ALU_ADD) || (alu_op_i == ALU_SUB);

  always_comb begin
    case (alu_op_i)
      ALU_ADD:           res = add_sum[31:0];
      ALU_SUB:           res = sub_sum[31:0];
      ALU_AND:           res = op_a & op_b;
      ALU_ORR:           res = op_a | op_b;
      ALU_EOR:           res = op_a ^ op_b;
      ALU_MOV, ALU_PASS_B: res = op_b;
      default:           res = op_b;
    endcase
  end

  // carry is not-borrow for subtract
  assign carry = (alu_op_i == ALU_SUB) ? sub_sum[32] : add_sum[32];
  assign ovf   = (alu_op_i == ALU_SUB) ?
                 (op_a[31] != op_b[31]) && (res[31] != op_a[31]) :
                 (op_a[31] == op_b[31]) && (res[31] != op_a[31]);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      {n_q, z_q, c_q, v_q} <= 4'b0000;
    end else if (pass && set_flags_i) begin
      n_q <= res[31];
      z_q <= res == 32'd0;
      if (arith) begin
        c_q <= carry;
        v_q <= ovf;
      end
    end
  end

  assign branch_o        = pass && is_branch_i;
  assign branch_target_o = res[`ADDR_W-1:0];  // pass-b of the decoded target

  // ************************************************************
  // stage register
  // ************************************************************
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o    <= 1'b0;
      do_write_o <= 1'b0;
      is_load_o  <= 1'b0;
      is_store_o <= 1'b0;
    end else begin
      valid_o    <= pass;
      do_write_o <= pass && rd_addr_i != `REG_PC;
      is_load_o  <= pass && is_load_i;
      is_store_o <= pass && is_store_i;
    end
  end

  always_ff @(posedge clk) begin
    rd_addr_o    <= rd_addr_i;
    alu_data_o   <= res;
    store_data_o <= reg_b;
    mem_addr_o   <= res[`ADDR_W-1:0];  // word address
  end

  a_branch_no_write: assert property (
    @(posedge clk) disable iff (!arst_n_i) branch_o |=> !do_write_o
  ) else $error("branch produced a register write");

endmodule

// File: src/fetch.sv
`include "cpu_consts.svh"

module fetch (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               run_i,
  input  logic               imem_we_i,
  input  logic [`ADDR_W-1:0] imem_addr_i,
  input  logic [31:0]        imem_data_i,
  input  logic               stall_i,
  input  logic               branch_i,
  input  logic [`ADDR_W-1:0] branch_target_i,
  output logic               valid_o,
  output logic [31:0]        inst_o,
  output logic [`ADDR_W-1:0] pc_o
);

  logic [31:0]        imem [`IMEM_DEPTH];
  logic [`ADDR_W-1:0] pc;

  // program load port, only while halted
  always_ff @(posedge clk) begin
    if (imem_we_i && !run_i) imem[imem_addr_i] <= imem_data_i;
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc      <= '0;
      valid_o <= 1'b0;
    end else if (!run_i) begin
      pc      <= '0;                // restart from word 0
      valid_o <= 1'b0;
    end else if (branch_i) begin
      pc      <= branch_target_i;
      valid_o <= 1'b0;              // flush the word in flight
    end else if (!stall_i) begin
      pc      <= pc + 1'b1;
      valid_o <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (run_i && !branch_i && !stall_i) begin
      inst_o <= imem[pc];
      pc_o   <= pc;
    end
  end

  a_no_load_while_running: assert property (
    @(posedge clk) disable iff (!arst_n_i) imem_we_i |-> !run_i
  ) else $error("instruction memory written while running");

endmodule

// File: src/mem_wb.sv
`include "cpu_consts.svh"

module mem_wb (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               valid_i,
  input  logic               do_write_i,
  input  logic [3:0]         rd_addr_i,
  input  logic [31:0]        alu_data_i,
  input  logic [31:0]        store_data_i,
  input  logic               is_load_i,
  input  logic               is_store_i,
  input  logic [`ADDR_W-1:0] mem_addr_i,
  output logic               wb_en_o,
  output logic [3:0]         wb_addr_o,
  output logic [31:0]        wb_data_o
);

  logic [31:0] dmem [`DMEM_DEPTH];

  always_ff @(posedge clk) begin
    if (valid_i && is_store_i) dmem[mem_addr_i] <= store_data_i;
  end

  // one write-back record per cycle
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) wb_en_o <= 1'b0;
    else           wb_en_o <= valid_i && do_write_i;
  end

  always_ff @(posedge clk) begin
    if (valid_i && do_write_i) begin
      wb_addr_o <= rd_addr_i;
      wb_data_o <= is_load_i ? dmem[mem_addr_i] : alu_data_i;  // load data or alu
    end
  end

  // full transfer address before it is cut to the word index
  a_addr_in_range: assert property (
    @(posedge clk) disable iff (!arst_n_i)
      valid_i && (is_load_i || is_store_i) |-> alu_data_i < `DMEM_DEPTH
  ) else $error("data address out of range");

endmodule

// File: testbench/cpu_tb.sv
`include "cpu_consts.svh"

module cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DATA_WORDS    = 128;
  localparam int SETTLE_CYCLES = 20;  // quiet window to catch stray writes

  logic               clk;
  logic               arst_n;
  logic               run;
  logic               imem_we;
  logic [`ADDR_W-1:0] imem_addr;
  logic [31:0]        imem_data;
  logic               wb_en;
  logic [3:0]         wb_addr;
  logic [31:0]        wb_data;

  logic [47:0] testdata [DATA_WORDS];  // program, then {group, reg, value} records
  int          prog_len     = 0;
  int          exp_count    = 0;
  int          rec_base     = 0;
  int          rec_idx      = 0;
  int          group_errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          errors       = 0;
  bit          all_seen     = 1'b0;

  cpu cpu_i (
    .clk         (clk),
    .arst_n_i    (arst_n),
    .run_i       (run),
    .imem_we_i   (imem_we),
    .imem_addr_i (imem_addr),
    .imem_data_i (imem_data),
    .wb_en_o     (wb_en),
    .wb_addr_o   (wb_addr),
    .wb_data_o   (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ************************************************************
  // helpers
  // ************************************************************
  function automatic string group_name(input logic [7:0] grp);
    case (grp)
      8'd1:    return "alu operations";
      8'd2:    return "back-to-back dependencies";
      8'd3:    return "flags and conditions";
      8'd4:    return "store then load";
      8'd5:    return "taken branch";
      default: return "unknown group";
    endcase
  endfunction

  task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
      @(posedge clk);
      #2;
      imem_we   = 1'b1;
      imem_addr = i[`ADDR_W-1:0];
      imem_data = testdata[i + 1][31:0];
    end
    @(posedge clk);
    #2 imem_we = 1'b0;
  endtask

  task automatic report_group(input logic [7:0] grp);
    if (group_errors == 0) begin
      $display("test %0d (%s): pass", grp, group_name(grp));
      tests_passed++;
    end else begin
      $display("test %0d (%s): FAIL, %0d errors", grp, group_name(grp), group_errors);
      tests_failed++;
    end
    group_errors = 0;
  endtask

  // compare one write-back against the next record
  task automatic check_write();
    logic [47:0] rec;
    logic [7:0]  grp;
    logic [3:0]  exp_addr;
    logic [31:0] exp_data;
    assert (rec_idx < exp_count) else begin
      $display("unexpected register write to r%0d with value 0x%h", wb_addr, wb_data);
      errors++;
    end
    if (rec_idx < exp_count) begin
      rec      = testdata[rec_base + rec_idx];
      grp      = rec[47:40];
      exp_addr = rec[35:32];
      exp_data = rec[31:0];
      assert (wb_addr === exp_addr) else begin
        $display("mismatch wb_addr_o: expected 0x%h, got 0x%h", exp_addr, wb_addr);
        group_errors++;
      end
      assert (wb_data === exp_data) else begin
        $display("mismatch wb_data_o: expected 0x%h, got 0x%h", exp_data, wb_data);
        group_errors++;
      end
      rec_idx++;
      if (rec_idx == exp_count) begin
        report_group(grp);
        all_seen = 1'b1;
      end else if (testdata[rec_base + rec_idx][47:40] != grp) begin
        report_group(grp);  // next record opens a new group
      end
    end
  endtask

  task automatic finish_run();
    $display("tests passed %0d, failed %0d, other errors %0d",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  // ************************************************************
  // stimulus and checking
  // ************************************************************
  always @(negedge clk) begin
    if (arst_n && wb_en) check_write();  // wb_en_o is stable mid-cycle
  end

  initial begin
    arst_n    = 1'b0;
    run       = 1'b0;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    $readmemh("testbench/cpu_testdata.hex", testdata);
    prog_len  = int'(testdata[0]);
    exp_count = int'(testdata[prog_len + 1]);
    rec_base  = prog_len + 2;
    repeat (2) @(posedge clk);
    #2 arst_n = 1'b1;
    load_program();
    @(posedge clk);
    #2 run = 1'b1;  // fetch starts from word 0
    wait (all_seen);
    repeat (SETTLE_CYCLES) @(posedge clk);
    finish_run();
  end

  initial begin : watchdog
    int limit;
    wait (run);
    limit = (prog_len + exp_count) * 8;
    repeat (limit) @(posedge clk);
    $display("timeout, register writes missing: got %0d of %0d", rec_idx, exp_count);
    $display("Something failed");
    $finish;
  end

endmodule

// File: testbench/cpu_testdata.hex
// one hex value per line: program length P, then P instruction words,
// then record count E, then E records {group[47:40], reg[39:32], value[31:0]}
00000026
E3A01005 // mov r1, #5
E3A0203C // mov r2, #0x3c
E2813010 // add r3, r1, #0x10
E2414007 // sub r4, r1, #7
E202500F // and r5, r2, #0x0f
E1816002 // orr r6, r1, r2
E22270FF // eor r7, r2, #0xff
E0428001 // sub r8, r2, r1
E3A09001 // mov r9, #1
E0899009 // add r9, r9, r9
E0899009 // add r9, r9, r9
E289A003 // add r10, r9, #3
E04AB009 // sub r11, r10, r9
E029C00B // eor r12, r9, r11
E3510005 // cmp r1, #5
03A00011 // moveq r0, #0x11
13A00022 // movne r0, #0x22
E3510009 // cmp r1, #9
B3A0D033 // movlt r13, #0x33
A3A0D044 // movge r13, #0x44
128DE001 // addne r14, r13, #1
E1510001 // cmp r1, r1
02800001 // addeq r0, r0, #1
A24DD003 // subge r13, r13, #3
B3A0E000 // movlt r14, #0
E3A01020 // mov r1, #0x20
E5812004 // str r2, [r1, #4]
E5017003 // str r7, [r1, #-3]
E5913004 // ldr r3, [r1, #4]
E5114003 // ldr r4, [r1, #-3]
E0845003 // add r5, r4, r3
EA000001 // b to word 34
E3A060AA // mov r6, #0xaa
E3A060BB // mov r6, #0xbb
E3A06077 // mov r6, #0x77
E2868001 // add r8, r6, #1
EAFFFFFE // b to itself
E3A060CC // mov r6, #0xcc
00000019
010100000005
01020000003C
010300000015
0104FFFFFFFE
01050000000C
01060000003D
0107000000C3
010800000037
020900000001
020900000002
020900000004
020A00000007
020B00000003
020C00000007
030000000011
030D00000033
030E00000034
030000000012
030D00000030
040100000020
04030000003C
0404000000C3
0405000000FF
050600000077
050800000078
